// File: Makefile
# Verilator build for the serial memory access unit

TOP       ?= mmu_board_tb
FILELIST  ?= mmu_board.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: mmu_board.f
+incdir+source
source/mmu_pkg.sv
source/spart.sv
source/host_cmd_decoder.sv
source/read_streamer.sv
source/mem_arbiter.sv
source/data_mem.sv
source/mmu_board.sv
verification/mmu_board_tb.sv

// File: source/data_mem.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module data_mem (
   input  logic              clk,
   input  mmu_pkg::mem_req_t mem_port,
   output mmu_pkg::word_t    rdata     // Valid the cycle after a read
);

   mmu_pkg::word_t mem [`MMU_DEPTH];

   always_ff @(posedge clk) begin
      if (mem_port.req) begin
         if (mem_port.we) begin
            mem[mem_port.addr] <= mem_port.wdata;
         end else begin
            rdata <= mem[mem_port.addr];  // Holds until the next read
         end
      end
   end

endmodule

// File: source/host_cmd_decoder.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module host_cmd_decoder (
   input  logic                clk,
   input  logic                rst,
   input  mmu_pkg::ser_byte_t  rx_byte,
   input  logic                rx_valid,
   output mmu_pkg::mem_req_t   wr_port,
   input  logic                wr_gnt,
   output logic                rd_start,   // One-cycle stream kick
   output mmu_pkg::addr_t      rd_addr,
   output mmu_pkg::ser_byte_t  rd_count,   // Words minus one
   input  logic                busy,       // Streamer still sending
   output mmu_pkg::dec_state_t state
);

   logic               is_rd;     // R command in flight
   logic [2:0]         byte_cnt;  // Data bytes taken
   mmu_pkg::addr_t     addr_q;
   mmu_pkg::word_t     data_q;
   mmu_pkg::ser_byte_t count_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= mmu_pkg::IDLE;
         is_rd    <= 1'b0;
         byte_cnt <= '0;
      end else begin
         case (state)
            mmu_pkg::IDLE: begin
               if (rx_valid && rx_byte == `MMU_CMD_WR) begin
                  is_rd <= 1'b0;
                  state <= mmu_pkg::ADDR_HI;
               end else if (rx_valid && rx_byte == `MMU_CMD_RD) begin
                  is_rd <= 1'b1;
                  state <= mmu_pkg::ADDR_HI;
               end
            end
            mmu_pkg::ADDR_HI: begin
               if (rx_valid) begin
                  state <= mmu_pkg::ADDR_LO;
               end
            end
            mmu_pkg::ADDR_LO: begin
               if (rx_valid) begin
                  byte_cnt <= '0;
                  state    <= is_rd ? mmu_pkg::COUNT : mmu_pkg::DATA;
               end
            end
            mmu_pkg::DATA: begin
               if (rx_valid) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == 3'd7) begin
                     state <= mmu_pkg::WRITE;  // Full word assembled
                  end
               end
            end
            mmu_pkg::WRITE: begin
               if (wr_gnt) begin
                  state <= mmu_pkg::IDLE;
               end
            end
            mmu_pkg::COUNT: begin
               if (rx_valid) begin
                  state <= mmu_pkg::START;
               end
            end
            default: state <= mmu_pkg::IDLE;  // START lasts one cycle
         endcase
      end
   end

   // Byte capture
   always_ff @(posedge clk) begin
      if (rx_valid) begin
         case (state)
            mmu_pkg::ADDR_HI: addr_q <= mmu_pkg::addr_t'({rx_byte, 8'h00});  // Top bits dropped
            mmu_pkg::ADDR_LO: addr_q[7:0] <= rx_byte;
            mmu_pkg::DATA:    data_q <= {rx_byte, data_q[63:8]};  // LSB first
            mmu_pkg::COUNT:   count_q <= rx_byte;
            default: ;
         endcase
      end
   end

   always_comb begin
      wr_port.req   = (state == mmu_pkg::WRITE);
      wr_port.we    = 1'b1;
      wr_port.addr  = addr_q;
      wr_port.wdata = data_q;
   end

   assign rd_start = (state == mmu_pkg::START) && !busy;  // Dropped if still streaming
   assign rd_addr  = addr_q;
   assign rd_count = count_q;

   // A write waits for the arbiter and is never withdrawn
   wr_hold_a: assert property (@(posedge clk) disable iff (rst)
      wr_port.req && !wr_gnt |=> wr_port.req)
      else $error("write request dropped before grant");

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
   input  mmu_pkg::mem_req_t wr_port,   // From command decoder
   output logic              wr_gnt,
   input  mmu_pkg::mem_req_t rd_port,   // From read streamer
   output logic              rd_gnt,
   output mmu_pkg::mem_req_t mem_port
);

   //////////////////////////////////////////////////////////////////////
   // Fixed priority with writes first
   //////////////////////////////////////////////////////////////////////
   assign wr_gnt = wr_port.req;
   assign rd_gnt = rd_port.req && !wr_port.req;  // Streamer waits a cycle

   // Winner drives the port
   always_comb begin
      if (wr_gnt) begin
         mem_port = wr_port;
      end else begin
         mem_port = rd_port;  // req is low unless rd_gnt
      end
   end

   // One requester per cycle on the single port
   always_comb begin
      gnt_onehot_a: assert (!(wr_gnt && rd_gnt))
         else $error("both memory grants high");
   end

endmodule

// File: source/mmu_board.sv
`timescale 1ns/1ps

module mmu_board (
   input  logic                clk,
   input  logic                rst,
   input  logic                rxd,     // RS232 from host
   output logic                txd,     // RS232 to host
   input  logic [1:0]          br_cfg,  // Baud select switches
   output mmu_pkg::dec_state_t state    // Decoder state for LEDs
);

   mmu_pkg::ser_byte_t rx_byte, tx_byte, rd_count;
   logic               rx_valid, tx_load, tx_busy;
   logic               wr_gnt, rd_gnt;
   logic               rd_start, busy;
   mmu_pkg::addr_t     rd_addr;
   mmu_pkg::mem_req_t  wr_port, rd_port, mem_port;
   mmu_pkg::word_t     rdata;

   //////////////////////////////////////////////////////////////////////
   // Serial side
   //////////////////////////////////////////////////////////////////////
   spart u_spart (
      .clk(clk), .rst(rst), .br_cfg(br_cfg), .rxd(rxd), .txd(txd),
      .rx_byte(rx_byte), .rx_valid(rx_valid),
      .tx_byte(tx_byte), .tx_load(tx_load), .tx_busy(tx_busy)
   );

   host_cmd_decoder u_decoder (
      .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
      .wr_port(wr_port), .wr_gnt(wr_gnt),
      .rd_start(rd_start), .rd_addr(rd_addr), .rd_count(rd_count),
      .busy(busy), .state(state)
   );

   read_streamer u_streamer (
      .clk(clk), .rst(rst), .rd_start(rd_start), .rd_addr(rd_addr),
      .rd_count(rd_count), .busy(busy), .rd_port(rd_port), .rd_gnt(rd_gnt),
      .rdata(rdata), .tx_byte(tx_byte), .tx_load(tx_load), .tx_busy(tx_busy)
   );

   //////////////////////////////////////////////////////////////////////
   // Memory side
   //////////////////////////////////////////////////////////////////////
   mem_arbiter u_arbiter (
      .wr_port(wr_port), .wr_gnt(wr_gnt),
      .rd_port(rd_port), .rd_gnt(rd_gnt),
      .mem_port(mem_port)
   );

   data_mem u_data_mem (.clk(clk), .mem_port(mem_port), .rdata(rdata));

endmodule

// File: source/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Data memory size
//////////////////////////////////////////////////////////////////////
`define MMU_DEPTH 16384  // 64-bit words

//////////////////////////////////////////////////////////////////////
// Clocks per serial bit, indexed by br_cfg
//////////////////////////////////////////////////////////////////////
`define MMU_DIV0 16      // Short divisors keep simulation quick
`define MMU_DIV1 32
`define MMU_DIV2 64
`define MMU_DIV3 128

// Host command bytes
`define MMU_CMD_WR 8'h57  // ASCII W
`define MMU_CMD_RD 8'h52  // ASCII R

`endif

// File: source/mmu_pkg.sv
`include "mmu_cfg.svh"

package mmu_pkg;

   // Word address into the data memory
   typedef logic [$clog2(`MMU_DEPTH)-1:0] addr_t;

   typedef logic [63:0] word_t;      // One memory word
   typedef logic [7:0]  ser_byte_t;  // One byte on the RS232 line
   typedef logic [15:0] div_t;       // Clocks per serial bit

   // Command decoder states, shown on the board LEDs
   typedef enum logic [3:0] {
      IDLE,     // Waiting for a command byte
      ADDR_HI,  // Upper address byte
      ADDR_LO,  // Lower address byte
      DATA,     // Eight write data bytes
      COUNT,    // Read word count
      WRITE,    // Holding the write request
      START     // Kicking off a read stream
   } dec_state_t;

   // Port bundle of one memory requester
   typedef struct packed {
      logic  req;    // Wants the port this cycle
      logic  we;     // Write when set
      addr_t addr;
      word_t wdata;  // Ignored on reads
   } mem_req_t;

endpackage

// File: source/read_streamer.sv
`timescale 1ns/1ps

module read_streamer (
   input  logic               clk,
   input  logic               rst,
   input  logic               rd_start,
   input  mmu_pkg::addr_t     rd_addr,
   input  mmu_pkg::ser_byte_t rd_count,
   output logic               busy,
   output mmu_pkg::mem_req_t  rd_port,
   input  logic               rd_gnt,
   input  mmu_pkg::word_t     rdata,
   output mmu_pkg::ser_byte_t tx_byte,
   output logic               tx_load,
   input  logic               tx_busy
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,    // Asking for the next word
      ST_LATCH,  // Read data arrives
      ST_SEND    // Feeding bytes to the SPART
   } str_state_t;

   str_state_t         st;
   logic [2:0]         byte_idx;  // Byte of the current word
   mmu_pkg::addr_t     addr_q;
   mmu_pkg::ser_byte_t left_q;    // Words remaining after this one
   mmu_pkg::word_t     word_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         st       <= ST_IDLE;
         byte_idx <= '0;
      end else begin
         case (st)
            ST_IDLE: begin
               if (rd_start) begin
                  st <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (rd_gnt) begin
                  st <= ST_LATCH;
               end
            end
            ST_LATCH: begin
               st       <= ST_SEND;
               byte_idx <= '0;
            end
            default: begin
               if (tx_load) begin
                  byte_idx <= byte_idx + 1'b1;
                  if (byte_idx == 3'd7) begin
                     st <= (left_q == '0) ? ST_IDLE : ST_REQ;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (st == ST_IDLE && rd_start) begin
         addr_q <= rd_addr;
         left_q <= rd_count;
      end else if (tx_load && byte_idx == 3'd7) begin
         addr_q <= addr_q + 1'b1;  // Wraps at top of memory
         left_q <= left_q - 1'b1;
      end
      if (st == ST_LATCH) begin
         word_q <= rdata;
      end else if (tx_load) begin
         word_q <= word_q >> 8;  // Next byte down to the bottom
      end
   end

   always_comb begin
      rd_port.req   = (st == ST_REQ);
      rd_port.we    = 1'b0;
      rd_port.addr  = addr_q;
      rd_port.wdata = '0;
   end

   assign busy    = (st != ST_IDLE);
   assign tx_load = (st == ST_SEND) && !tx_busy;
   assign tx_byte = word_q[7:0];

endmodule

// File: source/spart.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module spart (
   input  logic               clk,
   input  logic               rst,
   input  logic [1:0]         br_cfg,    // Baud select
   input  logic               rxd,       // RS232 receive line
   output logic               txd,       // RS232 transmit line
   output mmu_pkg::ser_byte_t rx_byte,
   output logic               rx_valid,  // One cycle per received byte
   input  mmu_pkg::ser_byte_t tx_byte,
   input  logic               tx_load,
   output logic               tx_busy
);

   mmu_pkg::div_t      bit_div;            // Clocks per bit
   logic               rxd_meta, rxd_sync; // Two-flop synchronizer
   logic               rx_active;          // Frame in progress
   mmu_pkg::div_t      rx_cnt;
   logic [3:0]         rx_bit;             // 0 start, 1 to 8 data, 9 stop
   mmu_pkg::ser_byte_t rx_shift;
   logic [9:0]         tx_shift;           // Stop, data, start
   mmu_pkg::div_t      tx_cnt;
   logic [3:0]         tx_bit;

   //////////////////////////////////////////////////////////////////////
   // Baud divisor
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      case (br_cfg)
         2'd0:    bit_div = mmu_pkg::div_t'(`MMU_DIV0);
         2'd1:    bit_div = mmu_pkg::div_t'(`MMU_DIV1);
         2'd2:    bit_div = mmu_pkg::div_t'(`MMU_DIV2);
         default: bit_div = mmu_pkg::div_t'(`MMU_DIV3);
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Receiver
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         rxd_meta <= 1'b1;  // Idle line is high
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rx_active <= 1'b0;
         rx_cnt    <= '0;
         rx_bit    <= '0;
         rx_valid  <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (!rx_active) begin
            if (!rxd_sync) begin  // Falling edge of start bit
               rx_active <= 1'b1;
               rx_cnt    <= (bit_div >> 1) - 1'b1;  // Half a bit to mid-start
               rx_bit    <= '0;
            end
         end else if (rx_cnt != '0) begin
            rx_cnt <= rx_cnt - 1'b1;
         end else begin
            // Middle of a bit
            rx_cnt <= bit_div - 1'b1;
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 4'd0) begin
               if (rxd_sync) begin
                  rx_active <= 1'b0;  // Glitch, not a start bit
               end
            end else if (rx_bit == 4'd9) begin
               rx_active <= 1'b0;
               rx_valid  <= rxd_sync;  // Bad stop bit drops the byte
            end
         end
      end
   end

   // LSB arrives first
   always_ff @(posedge clk) begin
      if (rx_active && rx_cnt == '0 && rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
         rx_shift <= {rxd_sync, rx_shift[7:1]};
      end
   end

   assign rx_byte = rx_shift;  // Stable until the next frame's data

   //////////////////////////////////////////////////////////////////////
   // Transmitter
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         tx_busy <= 1'b0;
         tx_cnt  <= '0;
         tx_bit  <= '0;
      end else if (!tx_busy) begin
         if (tx_load) begin
            tx_busy <= 1'b1;
            tx_cnt  <= bit_div - 1'b1;
            tx_bit  <= '0;
         end
      end else if (tx_cnt != '0) begin
         tx_cnt <= tx_cnt - 1'b1;
      end else if (tx_bit == 4'd9) begin
         tx_busy <= 1'b0;  // End of stop bit
      end else begin
         tx_cnt <= bit_div - 1'b1;
         tx_bit <= tx_bit + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (tx_load && !tx_busy) begin
         tx_shift <= {1'b1, tx_byte, 1'b0};
      end else if (tx_busy && tx_cnt == '0) begin
         tx_shift <= {1'b1, tx_shift[9:1]};  // Next bit onto the line
      end
   end

   assign txd = tx_busy ? tx_shift[0] : 1'b1;

   // Streamer must wait for the frame to finish
   tx_load_idle_a: assert property (@(posedge clk) disable iff (rst)
      tx_load |-> !tx_busy)
      else $error("tx_load while transmitter busy");

endmodule

// File: verification/mmu_board_tb.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_board_tb;

   localparam int CLK_PERIOD      = 100;
   localparam int NUM_WRITES      = 40;
   localparam int STREAM_WORDS    = 16;    // Long read for the contention test
   localparam int FRAMES_PER_PASS = 1500;  // Frames sent plus frames returned
   // Frames times 10 bits times divisor times 2 over both passes
   localparam int CYCLE_LIMIT = FRAMES_PER_PASS * 10 * (`MMU_DIV0 + `MMU_DIV1) * 2;

   logic                clk;
   logic                rst;
   logic                rxd;
   logic [1:0]          br_cfg;
   logic                txd;
   mmu_pkg::dec_state_t state;

   int                 bit_div;  // Clocks per bit of the current pass
   int                 errors;
   int                 checks;
   int                 cycles;
   mmu_pkg::word_t     model [mmu_pkg::addr_t];  // Memory model
   mmu_pkg::ser_byte_t got_q [$];                // Decoded from txd
   mmu_pkg::ser_byte_t exp_q [$];

   mmu_board u_mmu_board (
      .clk(clk), .rst(rst), .rxd(rxd), .txd(txd), .br_cfg(br_cfg), .state(state)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic check_byte(input string name, input mmu_pkg::ser_byte_t got,
                             input mmu_pkg::ser_byte_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_state(input mmu_pkg::dec_state_t got, input mmu_pkg::dec_state_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR: state = %h, expected %h", got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR: %s = %h, expected %h", name, got, exp);
      end
   endtask

   function automatic int div_for(input logic [1:0] cfg);
      case (cfg)
         2'd0:    return `MMU_DIV0;
         2'd1:    return `MMU_DIV1;
         2'd2:    return `MMU_DIV2;
         default: return `MMU_DIV3;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Serial driver
   //////////////////////////////////////////////////////////////////////
   task automatic send_byte(input mmu_pkg::ser_byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};  // Stop, data LSB first, start
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         #1 rxd = frame[i];
         repeat (bit_div - 1) @(posedge clk);
      end
      repeat (bit_div) @(posedge clk);  // One idle bit between frames
   endtask

   // Upper two address bits are ignored so junk goes there
   task automatic send_addr(input mmu_pkg::addr_t addr);
      logic [15:0] field;
      field = 16'(addr);
      field[15:14] = 2'($urandom);
      send_byte(field[15:8]);
      send_byte(field[7:0]);
   endtask

   task automatic send_write(input mmu_pkg::addr_t addr, input mmu_pkg::word_t data);
      send_byte(`MMU_CMD_WR);
      send_addr(addr);
      @(negedge clk);
      check_state(state, mmu_pkg::DATA);  // Address taken, data bytes next
      for (int j = 0; j < 8; j++) begin
         send_byte(data[8*j +: 8]);  // LSB first
      end
      model[addr] = data;
   endtask

   task automatic send_read(input mmu_pkg::addr_t addr, input int count);
      send_byte(`MMU_CMD_RD);
      send_addr(addr);
      @(negedge clk);
      check_state(state, mmu_pkg::COUNT);
      send_byte(mmu_pkg::ser_byte_t'(count));
   endtask

   // Expected stream of count+1 words wrapping at the top of memory
   task automatic queue_words(input mmu_pkg::addr_t addr, input int count);
      mmu_pkg::word_t w;
      for (int i = 0; i <= count; i++) begin
         w = model[mmu_pkg::addr_t'(addr + i)];
         for (int j = 0; j < 8; j++) begin
            exp_q.push_back(w[8*j +: 8]);
         end
      end
   endtask

   task automatic drain_bytes();
      mmu_pkg::ser_byte_t got;
      mmu_pkg::ser_byte_t exp;
      while (got_q.size() < exp_q.size()) @(negedge clk);  // Monitor catches up
      while (exp_q.size() > 0) begin
         got = got_q.pop_front();
         exp = exp_q.pop_front();
         check_byte("txd byte", got, exp);
      end
   endtask

   // Line must stay quiet for three frame times
   task automatic expect_silence();
      repeat (30 * bit_div) @(negedge clk);
      checks++;
      if (got_q.size() != 0) begin
         errors++;
         $display("Unexpected bytes on txd: %0d received", got_q.size());
         got_q.delete();
      end
   endtask

   task automatic apply_reset(input logic [1:0] cfg);
      @(posedge clk);
      #1;
      rst     = 1'b1;
      rxd     = 1'b1;
      br_cfg  = cfg;
      bit_div = div_for(cfg);
      repeat (8) @(posedge clk);
      #1 rst = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // One full pass at a given baud select
   //////////////////////////////////////////////////////////////////////
   task automatic run_pass(input logic [1:0] cfg);
      mmu_pkg::addr_t     addrs [NUM_WRITES];
      mmu_pkg::addr_t     base;
      mmu_pkg::ser_byte_t b;
      int                 cnt;
      apply_reset(cfg);
      repeat (20) begin
         @(negedge clk);
         check_bit("txd", txd, 1'b1);  // Idle line after reset
      end
      check_state(state, mmu_pkg::IDLE);

      // Random writes followed by one-word reads
      for (int i = 0; i < NUM_WRITES; i++) begin
         addrs[i] = mmu_pkg::addr_t'($urandom);
         send_write(addrs[i], {$urandom, $urandom});
      end
      for (int i = 0; i < NUM_WRITES; i++) begin
         send_read(addrs[i], 0);
         queue_words(addrs[i], 0);
         drain_bytes();
      end

      // Multi-word read across the top of memory
      cnt  = 2 + int'($urandom % 6);
      base = mmu_pkg::addr_t'(`MMU_DEPTH - 1 - int'($urandom % cnt));
      for (int i = 0; i <= cnt; i++) begin
         send_write(mmu_pkg::addr_t'(base + i), {$urandom, $urandom});
      end
      send_read(base, cnt);
      queue_words(base, cnt);
      drain_bytes();

      // Long stream with writes and a second R arriving meanwhile
      base = mmu_pkg::addr_t'($urandom % 8000);
      for (int i = 0; i < STREAM_WORDS; i++) begin
         send_write(mmu_pkg::addr_t'(base + i), {$urandom, $urandom});
      end
      send_read(base, STREAM_WORDS - 1);
      queue_words(base, STREAM_WORDS - 1);
      for (int i = 0; i < 4; i++) begin
         addrs[i] = mmu_pkg::addr_t'(base + STREAM_WORDS + int'($urandom % 4000));
         send_write(addrs[i], {$urandom, $urandom});
      end
      send_read(mmu_pkg::addr_t'($urandom), 3);  // Dropped while the streamer is busy
      drain_bytes();
      expect_silence();
      check_state(state, mmu_pkg::IDLE);
      for (int i = 0; i < 4; i++) begin
         send_read(addrs[i], 0);
         queue_words(addrs[i], 0);
         drain_bytes();
      end

      // Unknown command bytes
      for (int i = 0; i < 3; i++) begin
         do begin
            b = mmu_pkg::ser_byte_t'($urandom);
         end while (b == `MMU_CMD_WR || b == `MMU_CMD_RD);
         send_byte(b);
      end
      expect_silence();
      check_state(state, mmu_pkg::IDLE);
   endtask

   //////////////////////////////////////////////////////////////////////
   // txd monitor sampling mid-bit on the falling clock edge
   //////////////////////////////////////////////////////////////////////
   initial begin : txd_monitor
      mmu_pkg::ser_byte_t b;
      forever begin
         @(negedge clk);
         if (txd === 1'b0) begin
            repeat (bit_div / 2) @(negedge clk);  // Middle of start bit
            for (int i = 0; i < 8; i++) begin
               repeat (bit_div) @(negedge clk);
               b[i] = txd;
            end
            repeat (bit_div) @(negedge clk);
            if (txd !== 1'b1) begin
               errors++;
               $display("Stop bit missing on txd");
            end
            got_q.push_back(b);
         end
      end
   end

   initial begin : watchdog
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, DUT stopped responding", cycles);
      $display("Verification failed");
      $finish;
   end

   initial begin
      rst     = 1'b1;
      rxd     = 1'b1;
      br_cfg  = 2'd0;
      bit_div = div_for(2'd0);
      errors  = 0;
      checks  = 0;
      void'($urandom(38));
      run_pass(2'd0);
      run_pass(2'd1);  // Fresh reset at the slower rate
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
